// File: verilog/xreconf_pkg.sv
package xreconf_pkg;

   // operation requested by the host through the status register or a pch read
   typedef enum logic [2:0]
   {
      mode_read_lch  = 3'd0,  // fetch one word of a logical channel
      mode_write_lch = 3'd1,  // store one word, optionally merged or cleared
      mode_read_pch  = 3'd2   // physical channel lookup
   } xr_mode_e;

   // word registers of the host interface, 5 to 7 are reserved
   typedef enum logic [2:0]
   {
      xr_lch    = 3'd0,
      xr_pch    = 3'd1,
      xr_status = 3'd2,
      xr_offset = 3'd3,
      xr_data   = 3'd4
   } xr_addr_e;

   // channel controller sequence
   typedef enum logic [2:0]
   {
      st_idle    = 3'd0,  // waiting for go
      st_check   = 3'd1,  // range checks, first bank access
      st_rd_wait = 3'd2,  // bank read in flight
      st_rd_data = 3'd3,  // capture bank word for the host
      st_modify  = 3'd4,  // merge or clear, write back
      st_finish  = 3'd5   // last busy cycle
   } xr_state_e;

   // status word layout
   // bit 0 starts a write, bit 1 starts a read, bits 3:2 carry ctrl
   localparam int status_busy_bit  = 8;
   localparam int status_error_bit = 9;

   // tx and rx logical channels share one physical channel
   localparam int lch_per_pch = 2;

endpackage

// File: verilog/xreconf_user_if.sv
module xreconf_user_if
   import xreconf_pkg::*;
#(
   parameter int data_width   = 32,
   parameter int offset_width = 5,
   parameter int lch_width    = 10,
   parameter int enable_ctrl  = 1
)
(
   input  logic                        reconfig_clk,
   input  logic                        reset,

   // host register port
   input  logic [$bits(xr_addr_e)-1:0] address,
   input  logic [data_width-1:0]       writedata,
   input  logic                        write,
   input  logic                        read,
   output logic [data_width-1:0]       readdata,
   output logic                        waitrequest,
   output logic                        done,

   // from the channel controller
   input  logic [data_width-1:0]       readdata_ctl,
   input  logic [data_width-1:0]       pch_readdata,
   input  logic                        illegal_pch_error,
   input  logic                        illegal_offset_error,
   input  logic                        busy,

   // command to the channel controller
   output logic                        go,
   output xr_mode_e                    mode,
   output logic [1:0]                  ctrl,
   output logic [lch_width-1:0]        lch_addr,
   output logic [offset_width-1:0]     addr_offset,
   output logic [data_width-1:0]       wdata
);

   xr_addr_e                reg_sel;             // decoded register address
   logic                    addr_reserved;       // 5..7
   logic                    illegal_addr_error;  // sticky until the next legal access
   logic                    status_error;
   logic                    blocked;             // command pending or running
   logic                    wait_q;              // second cycle of a read
   logic                    done_en;             // host has read at least once
   logic [1:0]              ctrl_cmd;
   logic [data_width-1:0]   status_word;

   assign reg_sel       = xr_addr_e'(address);
   assign addr_reserved = (int'(address) > int'(xr_data));

   // go is high for one cycle before busy rises, so it blocks as well
   assign blocked = busy | go;

   assign status_error = illegal_addr_error | illegal_pch_error | illegal_offset_error;

   // one wait cycle per read
   assign waitrequest = read & ~wait_q;

   assign done = done_en & ~busy & ~go;  // low while a command is in flight

   // ctrl bits only taken when the modifiers are built in
   assign ctrl_cmd = (enable_ctrl != 0) ? writedata[3:2] : 2'b00;

   always_comb
   begin
      status_word                   = '0;
      status_word[3:2]              = ctrl;  // stays zero without enable_ctrl
      status_word[status_busy_bit]  = busy;
      status_word[status_error_bit] = status_error;
   end

   // register writes and command launch
   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         lch_addr           <= '0;
         addr_offset        <= '0;
         wdata              <= '0;
         mode               <= mode_read_lch;
         ctrl               <= 2'b00;
         go                 <= 1'b0;
         illegal_addr_error <= 1'b0;
      end
      else
      begin
         go <= 1'b0;  // strobe

         if (read || write)
            illegal_addr_error <= addr_reserved;  // any legal access clears it

         case (reg_sel)
            xr_lch:
            begin
               if (write && !blocked)
                  lch_addr <= writedata[lch_width-1:0];
            end
            xr_offset:
            begin
               if (write && !blocked)
                  addr_offset <= writedata[offset_width-1:0];
            end
            xr_data:
            begin
               if (write && !blocked)
                  wdata <= writedata;
            end
            xr_status:
            begin
               if (write && !blocked)
               begin
                  ctrl <= ctrl_cmd;
                  if (writedata[0])  // write has priority over read
                  begin
                     go   <= 1'b1;
                     mode <= mode_write_lch;
                  end
                  else if (writedata[1])
                  begin
                     go   <= 1'b1;
                     mode <= mode_read_lch;
                  end
               end
            end
            xr_pch:
            begin
               // lookup starts on the first read cycle only
               if (waitrequest && !blocked)
               begin
                  go   <= 1'b1;
                  mode <= mode_read_pch;
               end
            end
            default:
            begin
               go <= 1'b0;  // reserved address, nothing to launch
            end
         endcase
      end
   end

   // read mux, sampled in the first read cycle and held through the second
   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         readdata <= '0;
         wait_q   <= 1'b0;
         done_en  <= 1'b0;
      end
      else
      begin
         wait_q <= waitrequest;
         if (read)
            done_en <= 1'b1;

         if (waitrequest)
         begin
            case (reg_sel)
               xr_lch:    readdata <= data_width'(lch_addr);
               xr_offset: readdata <= data_width'(addr_offset);
               xr_status: readdata <= status_word;
               xr_pch:
               begin
                  if (!blocked)
                     readdata <= pch_readdata;  // result of the previous lookup
               end
               xr_data:
               begin
                  if (!blocked)
                     readdata <= (mode == mode_write_lch) ? wdata : readdata_ctl;
               end
               default:   readdata <= '0;
            endcase
         end
      end
   end

endmodule

// File: verilog/xreconf_ch_control.sv
module xreconf_ch_control
   import xreconf_pkg::*;
#(
   parameter int data_width   = 32,
   parameter int offset_width = 5,
   parameter int lch_width    = 10,
   parameter int num_lch      = 8,
   parameter int num_offsets  = 24,
   localparam int index_width = $clog2(num_lch * num_offsets)
)
(
   input  logic                     reconfig_clk,
   input  logic                     reset,

   // command from the user interface
   input  logic                     go,
   input  xr_mode_e                 mode,
   input  logic [1:0]               ctrl,
   input  logic [lch_width-1:0]     lch_addr,
   input  logic [offset_width-1:0]  addr_offset,
   input  logic [data_width-1:0]    wdata,

   // status and results
   output logic                     busy,
   output logic [data_width-1:0]    readdata,
   output logic [data_width-1:0]    pch_readdata,
   output logic                     illegal_pch_error,
   output logic                     illegal_offset_error,

   // register bank port
   output logic                     bank_wr,
   output logic                     bank_rd,
   output logic [index_width-1:0]   bank_index,
   output logic [data_width-1:0]    bank_wdata,
   input  logic [data_width-1:0]    bank_rdata
);

   xr_state_e               state;
   xr_mode_e                cmd_mode;
   logic [1:0]              cmd_ctrl;
   logic [lch_width-1:0]    cmd_lch;     // command copy taken at go
   logic [offset_width-1:0] cmd_offset;
   logic [data_width-1:0]   cmd_wdata;
   logic                    lch_bad;
   logic                    offset_bad;
   logic                    need_read;   // read or read-modify-write
   logic [data_width-1:0]   pch_value;
   logic [data_width-1:0]   merged_word;

   assign busy = (state != st_idle);

   assign lch_bad    = (int'(cmd_lch) >= num_lch);
   // pch lookups ignore the offset
   assign offset_bad = (int'(cmd_offset) >= num_offsets) && (cmd_mode != mode_read_pch);

   assign need_read = (cmd_mode == mode_read_lch) ||
                      ((cmd_mode == mode_write_lch) && (cmd_ctrl != 2'b00));

   assign pch_value = data_width'(int'(cmd_lch) / lch_per_pch);

   // bit 0 merges, otherwise bit 1 clears
   assign merged_word = cmd_ctrl[0] ? (bank_rdata | cmd_wdata) : (bank_rdata & ~cmd_wdata);

   // word location inside the bank
   assign bank_index = index_width'(int'(cmd_lch) * num_offsets + int'(cmd_offset));

   // payload copies
   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         cmd_lch    <= '0;
         cmd_offset <= '0;
         cmd_wdata  <= '0;
         bank_wdata <= '0;
      end
      else
      begin
         if (go && (state == st_idle))
         begin
            cmd_lch    <= lch_addr;
            cmd_offset <= addr_offset;
            cmd_wdata  <= wdata;
         end

         if (state == st_check)
            bank_wdata <= cmd_wdata;     // plain write
         else if (state == st_modify)
            bank_wdata <= merged_word;   // write back after merge or clear
      end
   end

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         state                <= st_idle;
         cmd_mode             <= mode_read_lch;
         cmd_ctrl             <= 2'b00;
         illegal_pch_error    <= 1'b0;
         illegal_offset_error <= 1'b0;
         readdata             <= '0;
         pch_readdata         <= '0;
         bank_wr              <= 1'b0;
         bank_rd              <= 1'b0;
      end
      else
      begin
         bank_wr <= 1'b0;  // both strobes last one cycle
         bank_rd <= 1'b0;

         case (state)
            st_idle:
            begin
               if (go)
               begin
                  cmd_mode             <= mode;
                  cmd_ctrl             <= ctrl;
                  illegal_pch_error    <= 1'b0;  // errors describe the latest command
                  illegal_offset_error <= 1'b0;
                  state                <= st_check;
               end
            end
            st_check:
            begin
               if (lch_bad || offset_bad)
               begin
                  illegal_pch_error    <= lch_bad;
                  illegal_offset_error <= offset_bad;
                  state                <= st_finish;  // bank untouched
               end
               else if (cmd_mode == mode_read_pch)
               begin
                  pch_readdata <= pch_value;
                  readdata     <= pch_value;  // also visible through the data register
                  state        <= st_finish;
               end
               else if (need_read)
               begin
                  bank_rd <= 1'b1;
                  state   <= st_rd_wait;
               end
               else
               begin
                  bank_wr <= 1'b1;  // lands during finish
                  state   <= st_finish;
               end
            end
            st_rd_wait:
               state <= (cmd_mode == mode_write_lch) ? st_modify : st_rd_data;
            st_rd_data:
            begin
               readdata <= bank_rdata;
               state    <= st_finish;
            end
            st_modify:
            begin
               bank_wr <= 1'b1;
               state   <= st_finish;
            end
            st_finish:
               state <= st_idle;  // busy drops here
            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

// File: verilog/xreconf_reg_bank.sv
module xreconf_reg_bank
#(
   parameter int data_width   = 32,
   parameter int num_lch      = 8,
   parameter int num_offsets  = 24,
   localparam int depth       = num_lch * num_offsets,
   localparam int index_width = $clog2(depth)
)
(
   input  logic                   reconfig_clk,
   input  logic                   reset,

   // controller port, one word per access
   input  logic                   bank_wr,
   input  logic                   bank_rd,
   input  logic [index_width-1:0] bank_index,
   input  logic [data_width-1:0]  bank_wdata,
   output logic [data_width-1:0]  bank_rdata
);

   // one row of num_offsets words per logical channel
   logic [data_width-1:0] mem [depth];
   logic                  index_ok;

   // the index space is a power of two, the bank may be smaller
   assign index_ok = (int'(bank_index) < depth);

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
            mem[i] <= '0;  // every channel starts from zero
         bank_rdata <= '0;
      end
      else
      begin
         if (bank_wr && index_ok)
            mem[bank_index] <= bank_wdata;

         // registered read, old word on a same-cycle write
         if (bank_rd)
            bank_rdata <= index_ok ? mem[bank_index] : '0;
      end
   end

endmodule

// File: verilog/xreconf_top.sv
module xreconf_top
   import xreconf_pkg::*;
#(
   parameter int data_width   = 32,
   parameter int offset_width = 5,
   parameter int lch_width    = 10,
   parameter int num_lch      = 8,   // even, two per physical channel
   parameter int num_offsets  = 24,
   parameter int enable_ctrl  = 1
)
(
   input  logic                        reconfig_clk,
   input  logic                        reset,
   input  logic [$bits(xr_addr_e)-1:0] address,
   input  logic [data_width-1:0]       writedata,
   input  logic                        write,
   input  logic                        read,
   output logic [data_width-1:0]       readdata,
   output logic                        waitrequest,
   output logic                        done
);

   localparam int index_width = $clog2(num_lch * num_offsets);

   // user interface to controller
   logic                    go;
   xr_mode_e                mode;
   logic [1:0]              ctrl;
   logic [lch_width-1:0]    lch_addr;
   logic [offset_width-1:0] addr_offset;
   logic [data_width-1:0]   wdata;
   logic                    busy;
   logic [data_width-1:0]   readdata_ctl;
   logic [data_width-1:0]   pch_readdata;
   logic                    illegal_pch_error;
   logic                    illegal_offset_error;

   // controller to bank
   logic                    bank_wr;
   logic                    bank_rd;
   logic [index_width-1:0]  bank_index;
   logic [data_width-1:0]   bank_wdata;
   logic [data_width-1:0]   bank_rdata;

   xreconf_user_if #(
      .data_width   (data_width),
      .offset_width (offset_width),
      .lch_width    (lch_width),
      .enable_ctrl  (enable_ctrl)
   ) user_if_i (
      .reconfig_clk         (reconfig_clk),
      .reset                (reset),
      .address              (address),
      .writedata            (writedata),
      .write                (write),
      .read                 (read),
      .readdata             (readdata),
      .waitrequest          (waitrequest),
      .done                 (done),
      .readdata_ctl         (readdata_ctl),
      .pch_readdata         (pch_readdata),
      .illegal_pch_error    (illegal_pch_error),
      .illegal_offset_error (illegal_offset_error),
      .busy                 (busy),
      .go                   (go),
      .mode                 (mode),
      .ctrl                 (ctrl),
      .lch_addr             (lch_addr),
      .addr_offset          (addr_offset),
      .wdata                (wdata)
   );

   xreconf_ch_control #(
      .data_width   (data_width),
      .offset_width (offset_width),
      .lch_width    (lch_width),
      .num_lch      (num_lch),
      .num_offsets  (num_offsets)
   ) ch_control_i (
      .reconfig_clk         (reconfig_clk),
      .reset                (reset),
      .go                   (go),
      .mode                 (mode),
      .ctrl                 (ctrl),
      .lch_addr             (lch_addr),
      .addr_offset          (addr_offset),
      .wdata                (wdata),
      .busy                 (busy),
      .readdata             (readdata_ctl),
      .pch_readdata         (pch_readdata),
      .illegal_pch_error    (illegal_pch_error),
      .illegal_offset_error (illegal_offset_error),
      .bank_wr              (bank_wr),
      .bank_rd              (bank_rd),
      .bank_index           (bank_index),
      .bank_wdata           (bank_wdata),
      .bank_rdata           (bank_rdata)
   );

   xreconf_reg_bank #(
      .data_width  (data_width),
      .num_lch     (num_lch),
      .num_offsets (num_offsets)
   ) reg_bank_i (
      .reconfig_clk (reconfig_clk),
      .reset        (reset),
      .bank_wr      (bank_wr),
      .bank_rd      (bank_rd),
      .bank_index   (bank_index),
      .bank_wdata   (bank_wdata),
      .bank_rdata   (bank_rdata)
   );

endmodule

// File: testbench/tb_xreconf_tests.svh
`ifndef TB_XRECONF_TESTS_SVH
`define TB_XRECONF_TESTS_SVH

// 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] next_random();
   rng_state = rng_state ^ (rng_state << 13);
   rng_state = rng_state ^ (rng_state >> 17);
   rng_state = rng_state ^ (rng_state << 5);
   return rng_state;
endfunction

task automatic check_data(input string name, input logic [data_width-1:0] expected,
                          input logic [data_width-1:0] actual);
   check_count++;
   if (actual !== expected)
   begin
      error_count++;
      $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
   end
endtask

// compares the busy and error bits as {busy, error}
task automatic check_status(input string name, input logic exp_busy, input logic exp_error,
                            input logic [data_width-1:0] word);
   logic [1:0] actual;
   actual = {word[status_busy_bit], word[status_error_bit]};
   check_count++;
   if (actual !== {exp_busy, exp_error})
   begin
      error_count++;
      $display("[FAIL] %s busy/error expected 0x%h actual 0x%h", name,
               {exp_busy, exp_error}, actual);
   end
endtask

task automatic check_pch(input string name, input logic [lch_width-1:0] expected,
                         input logic [data_width-1:0] actual);
   check_count++;
   if (actual !== data_width'(expected))
   begin
      error_count++;
      $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
   end
endtask

// write is sampled on the next edge
task automatic bus_write(input logic [2:0] addr, input logic [data_width-1:0] data);
   address   = addr;
   writedata = data;
   write     = 1'b1;
   @(posedge clk);
   #1;
   write = 1'b0;
endtask

task automatic bus_read(input logic [2:0] addr, output logic [data_width-1:0] data);
   int wait_cycles;
   wait_cycles = 0;
   address     = addr;
   read        = 1'b1;
   @(negedge clk);  // mid first cycle
   if (waitrequest)
      wait_cycles++;
   @(posedge clk);
   #1;
   while (waitrequest)  // only a broken DUT stays here
   begin
      wait_cycles++;
      @(posedge clk);
      #1;
   end
   data = readdata;
   @(posedge clk);  // read completes on this edge
   #1;
   read = 1'b0;
   check_data("waitrequest cycles", data_width'(1), data_width'(wait_cycles));
endtask

task automatic wait_done();
   while (!done)
   begin
      @(posedge clk);
      #1;
   end
endtask

// full write command with the model following the ctrl rules
task automatic write_word(input int lch, input int off, input logic [data_width-1:0] data,
                          input logic [1:0] ctrl);
   int idx;
   idx = lch * num_offsets + off;
   bus_write(xr_lch, data_width'(lch));
   bus_write(xr_offset, data_width'(off));
   bus_write(xr_data, data);
   bus_write(xr_status, data_width'({ctrl, 2'b01}));  // bit 0 starts the write
   wait_done();
   if (ctrl == 2'b00)
      model[idx] = data;
   else if (ctrl[0])
      model[idx] = model[idx] | data;  // merge
   else
      model[idx] = model[idx] & ~data;  // clear
endtask

task automatic read_word(input int lch, input int off, output logic [data_width-1:0] data);
   bus_write(xr_lch, data_width'(lch));
   bus_write(xr_offset, data_width'(off));
   bus_write(xr_status, data_width'(2));  // bit 1 starts the read
   wait_done();
   bus_read(xr_data, data);
endtask

task automatic test_reset_readback();
   logic [data_width-1:0] word;
   check_data("done", '0, data_width'(done));  // no read yet
   bus_read(xr_status, word);
   check_status("status after reset", 1'b0, 1'b0, word);
   check_data("status", '0, word);
   bus_write(xr_lch, data_width'(5));
   bus_write(xr_offset, data_width'(17));
   bus_read(xr_lch, word);
   check_data("lch", data_width'(5), word);
   bus_read(xr_offset, word);
   check_data("offset", data_width'(17), word);
   read_word(0, 0, word);
   check_data("bank word after reset", '0, word);
endtask

task automatic test_write_read();
   int                    lchs [20];
   int                    offs [20];
   logic [data_width-1:0] data;
   logic [data_width-1:0] word;
   for (int i = 0; i < 20; i++)
   begin
      lchs[i] = int'(next_random() % num_lch);
      offs[i] = int'(next_random() % num_offsets);
      if (i == 12)
      begin
         lchs[i] = lchs[4];  // overwrite an earlier word
         offs[i] = offs[4];
      end
      data = next_random();
      write_word(lchs[i], offs[i], data, 2'b00);
      bus_read(xr_data, word);  // data register holds the write data now
      check_data("data register", data, word);
   end
   for (int i = 0; i < 20; i++)
   begin
      read_word(lchs[i], offs[i], word);
      check_data("bank word", model[lchs[i] * num_offsets + offs[i]], word);
   end
endtask

task automatic test_pch_lookup();
   logic [data_width-1:0] word;
   for (int lch = 0; lch < num_lch; lch++)
   begin
      bus_write(xr_lch, data_width'(lch));
      bus_read(xr_pch, word);  // starts the lookup and returns the last result
      wait_done();
      bus_read(xr_pch, word);
      check_pch("pch", lch_width'(lch / lch_per_pch), word);
      wait_done();  // second read launched another lookup
   end
endtask

task automatic test_illegal_commands();
   logic [data_width-1:0] word;
   write_word(1, 0, 32'h5a5a_0ff0, 2'b00);
   // offset 24 of channel 0 would alias channel 1 offset 0
   bus_write(xr_lch, data_width'(0));
   bus_write(xr_offset, data_width'(num_offsets));
   bus_write(xr_data, 32'hdead_beef);
   bus_write(xr_status, data_width'(1));
   wait_done();
   bus_read(xr_status, word);
   check_status("status after bad offset", 1'b0, 1'b1, word);
   read_word(1, 0, word);
   check_data("bank word after bad offset", model[num_offsets], word);
   bus_write(xr_lch, data_width'(num_lch));
   bus_write(xr_offset, data_width'(0));
   bus_write(xr_status, data_width'(1));
   wait_done();
   bus_read(xr_status, word);
   check_status("status after bad lch", 1'b0, 1'b1, word);
   read_word(num_lch - 1, 0, word);
   check_data("bank word after bad lch", model[(num_lch - 1) * num_offsets], word);
   bus_read(xr_status, word);
   check_status("status after legal read", 1'b0, 1'b0, word);
   bus_read(3'd5, word);  // reserved read
   bus_read(xr_status, word);
   check_status("status after reserved read", 1'b0, 1'b1, word);
   bus_read(xr_status, word);
   check_status("status after legal access", 1'b0, 1'b0, word);
   bus_write(3'd6, 32'h1234_5678);  // reserved write
   bus_read(xr_status, word);
   check_status("status after reserved write", 1'b0, 1'b1, word);
   bus_read(xr_status, word);
   check_status("status after legal access", 1'b0, 1'b0, word);
endtask

task automatic test_ctrl_modifiers();
   logic [data_width-1:0] word;
   write_word(2, 5, next_random(), 2'b00);
   write_word(2, 5, next_random(), 2'b01);  // or into the word
   bus_read(xr_status, word);
   check_data("status ctrl", data_width'(1), data_width'(word[3:2]));
   read_word(2, 5, word);
   check_data("merged word", model[2 * num_offsets + 5], word);
   write_word(2, 5, next_random(), 2'b10);  // and-not
   bus_read(xr_status, word);
   check_data("status ctrl", data_width'(2), data_width'(word[3:2]));
   read_word(2, 5, word);
   check_data("cleared word", model[2 * num_offsets + 5], word);
endtask

task automatic test_busy_protection();
   logic [data_width-1:0] word;
   bus_write(xr_lch, data_width'(3));
   bus_write(xr_offset, data_width'(4));
   bus_write(xr_status, data_width'(2));
   bus_write(xr_lch, data_width'(6));  // go is high here so the write is dropped
   bus_read(xr_status, word);
   check_status("status while busy", 1'b1, 1'b0, word);
   wait_done();
   bus_read(xr_lch, word);
   check_data("lch after busy write", data_width'(3), word);
   bus_read(xr_data, word);
   check_data("read during busy test", model[3 * num_offsets + 4], word);
endtask

`endif

// File: testbench/tb_xreconf.sv
module tb_xreconf
   import xreconf_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // same values as the xreconf_top defaults
   localparam int data_width   = 32;
   localparam int offset_width = 5;
   localparam int lch_width    = 10;
   localparam int num_lch      = 8;
   localparam int num_offsets  = 24;
   localparam int enable_ctrl  = 1;

   // about 1200 cycles of tests in total, the rest is margin
   localparam int timeout_cycles = 4000;

   logic                  clk;
   logic                  reset;
   logic [2:0]            address;
   logic [data_width-1:0] writedata;
   logic                  write;
   logic                  read;
   logic [data_width-1:0] readdata;
   logic                  waitrequest;
   logic                  done;

   // expected bank contents, one row of num_offsets words per channel
   logic [data_width-1:0] model [num_lch * num_offsets];
   logic [31:0]           rng_state;
   int                    error_count;
   int                    check_count;
   int                    cycle_count;

   xreconf_top #(
      .data_width   (data_width),
      .offset_width (offset_width),
      .lch_width    (lch_width),
      .num_lch      (num_lch),
      .num_offsets  (num_offsets),
      .enable_ctrl  (enable_ctrl)
   ) dut_i (
      .reconfig_clk (clk),
      .reset        (reset),
      .address      (address),
      .writedata    (writedata),
      .write        (write),
      .read         (read),
      .readdata     (readdata),
      .waitrequest  (waitrequest),
      .done         (done)
   );

   always #2 clk = ~clk;  // 4 ns period

   `include "tb_xreconf_tests.svh"

   // guard against a DUT that never finishes a command or a read
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles)
      begin
         $display("timeout: done never rose within %0d cycles", timeout_cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      address     = '0;
      writedata   = '0;
      write       = 1'b0;
      read        = 1'b0;
      rng_state   = 32'h3c0b;
      error_count = 0;
      check_count = 0;
      cycle_count = 0;
      for (int i = 0; i < num_lch * num_offsets; i++)
         model[i] = '0;  // bank is cleared by reset

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;  // inputs change 1 ns after the edge from here on

      test_reset_readback();
      test_write_read();
      test_pch_lookup();
      test_illegal_commands();
      test_ctrl_modifiers();
      test_busy_protection();

      $display("checks: %0d errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: files.f
+incdir+testbench
verilog/xreconf_pkg.sv
verilog/xreconf_user_if.sv
verilog/xreconf_ch_control.sv
verilog/xreconf_reg_bank.sv
verilog/xreconf_top.sv
testbench/tb_xreconf.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_xreconf -f files.f -o tb_xreconf_sim
./obj_dir/tb_xreconf_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log
then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"
